//--- hw/mipsIsaPkg.sv
// Instruction set definitions of the MIPS-style core
// Opcode and funct codes, instruction field layout, register index type

package mipsIsaPkg;

   // Register file shape
   localparam int regCount = 32;           // Architectural registers, r0 fixed zero
   typedef logic [4:0] regIdxT;

   // Field widths reached as slices of the instruction word
   localparam int immW     = 16;           // I-type immediate, bits 15..0
   localparam int jumpIdxW = 26;           // J-type word index, bits 25..0

   // Major opcode, bits 31..26
   typedef enum logic [5:0] {
      opRType = 6'h00,                     // ALU ops, funct decides
      opJ     = 6'h02,
      opBeq   = 6'h04,
      opAddi  = 6'h08,
      opLb    = 6'h20,                     // Load byte, sign extended
      opLw    = 6'h23,
      opSw    = 6'h2b
   } opcodeT;

   // R-type function codes, bits 5..0
   typedef enum logic [5:0] {
      fnAdd = 6'h20,
      fnSub = 6'h22,
      fnAnd = 6'h24,
      fnOr  = 6'h25,
      fnXor = 6'h26,
      fnSlt = 6'h2a                        // Not decoded, lands on XNOR
   } functT;

   // Raw field view of one instruction
   typedef struct packed {
      opcodeT     opcode;
      regIdxT     rs;
      regIdxT     rt;
      regIdxT     rd;
      logic [4:0] shamt;
      logic [5:0] funct;                   // Kept raw, may hold unknown codes
   } instrT;

endpackage

//--- hw/datapathCtrlPkg.sv
// Datapath widths, controller select encodings and fixed constants
// Shared by the datapath blocks and the external controller

package datapathCtrlPkg;

   localparam int wordW  = 32;
   localparam int blockW = 4;              // Lookahead block size of the adder
   localparam int byteW  = 8;

   typedef logic [wordW-1:0] wordT;

   // ALUOp mode from the controller
   typedef enum logic [1:0] {
      forceAdd = 2'b00,                    // Fetch, address calc
      forceSub = 2'b01,                    // Branch compare
      byFunct  = 2'b10                     // R-type, funct decides
   } aluOpModeT;

   // ALU operation, top bit inverts operand B
   typedef enum logic [2:0] {
      aluAnd  = 3'b000,
      aluOr   = 3'b001,
      aluAdd  = 3'b010,
      aluXor  = 3'b011,
      aluSub  = 3'b110,
      aluXnor = 3'b111
   } aluOperT;

   // ALU operand B source
   typedef enum logic [1:0] {selB, selFour, selImm, selImmShift} srcBSelT;

   // Next-PC source
   typedef enum logic [1:0] {pcAlu, pcAluReg, pcJump, pcVector} pcSourceT;

   localparam wordT exceptionVector = 32'hc000_0000;
   localparam wordT pcStep          = 32'd4;

endpackage

//--- hw/aluBus.sv
// Operand, control and result bundle around the ALU
// Datapath drives operands and mode, control decodes, compute answers

interface aluBus;
   import datapathCtrlPkg::*;
   import mipsIsaPkg::*;

   wordT      opA;                         // Operand A after source select
   wordT      opB;                         // Operand B after source select
   functT     funct;                       // Funct field of the held instruction
   aluOpModeT mode;                        // ALUOp from the controller
   aluOperT   operation;                   // Decoded ALU operation
   wordT      result;
   logic      zero;
   logic      overflow;

   modport datapath (output opA, opB, funct, mode, input result, zero, overflow);
   modport control  (input mode, funct, output operation);
   modport compute  (input opA, opB, operation, output result, zero, overflow);

endinterface

//--- hw/claAdder.sv
// 32-bit carry-select adder built from 4-bit lookahead blocks
// Each block precomputes carries for both carry-in values, the chain picks one

module claAdder (
   input  datapathCtrlPkg::wordT a,
   input  datapathCtrlPkg::wordT b,
   input  logic                  subtract,  // Invert b, carry in 1
   output datapathCtrlPkg::wordT sum,
   output logic                  overflow   // Signed overflow
);
   import datapathCtrlPkg::*;

   wordT                      bEff;         // b after optional inversion
   wordT                      carry0;       // Block carries for carry-in 0
   wordT                      carry1;       // Block carries for carry-in 1
   wordT                      carry;        // Selected carry out of each bit
   logic [wordW/blockW:0]     blockCin;     // Carry into each block

   // Lookahead carries of one block
   function automatic logic [blockW-1:0] lookahead(
      input logic [blockW-1:0] x,
      input logic [blockW-1:0] y,
      input logic              cin
   );
      logic [blockW-1:0] g;
      logic [blockW-1:0] p;
      logic [blockW-1:0] c;
      g    = x & y;                         // Generate
      p    = x | y;                         // Propagate
      c[0] = g[0] | (p[0] & cin);
      c[1] = g[1] | (p[1] & g[0]) | (&p[1:0] & cin);
      c[2] = g[2] | (p[2] & g[1]) | (&p[2:1] & g[0]) | (&p[2:0] & cin);
      c[3] = g[3] | (p[3] & g[2]) | (&p[3:2] & g[1]) | (&p[3:1] & g[0])
           | (&p[3:0] & cin);
      return c;
   endfunction

   assign bEff        = subtract ? ~b : b;
   assign blockCin[0] = subtract;           // Two's complement +1

   // ~~~~~~~~~~~~~~ Carry-select chain ~~~~~~~~~~~~~~
   for (genvar k = 0; k < wordW / blockW; k++)
   begin : gBlock
      assign carry0[k*blockW +: blockW] =
         lookahead(a[k*blockW +: blockW], bEff[k*blockW +: blockW], 1'b0);
      assign carry1[k*blockW +: blockW] =
         lookahead(a[k*blockW +: blockW], bEff[k*blockW +: blockW], 1'b1);
      assign carry[k*blockW +: blockW]  =
         blockCin[k] ? carry1[k*blockW +: blockW] : carry0[k*blockW +: blockW];
      assign blockCin[k+1] = carry[k*blockW + blockW - 1];   // Feeds next block
   end

   // Sum bit is a ^ b ^ carry into that bit
   assign sum      = a ^ bEff ^ {carry[wordW-2:0], blockCin[0]};
   assign overflow = carry[wordW-1] ^ carry[wordW-2];   // Carry in vs out of MSB

endmodule

//--- hw/alu.sv
// ALU of the datapath: logic ops, add and subtract, zero and overflow
// Operation comes decoded from aluControl over the bus

module alu (
   aluBus.compute bus
);
   import datapathCtrlPkg::*;

   wordT bOper;                             // B, inverted when top op bit set
   wordT andRes;
   wordT orRes;
   wordT xorRes;                            // XNOR when B inverted
   wordT sumRes;
   logic adderOvf;

   assign bOper  = bus.operation[2] ? ~bus.opB : bus.opB;
   assign andRes = bus.opA & bOper;
   assign orRes  = bus.opA | bOper;
   assign xorRes = bus.opA ^ bOper;

   // Adder does its own inversion for subtract
   claAdder adder (
      .a        (bus.opA),
      .b        (bus.opB),
      .subtract (bus.operation[2]),
      .sum      (sumRes),
      .overflow (adderOvf)
   );

   // ~~~~~~~~~~~~~~~~ Result select ~~~~~~~~~~~~~~~~
   always_comb
   begin
      case (bus.operation)
         aluAnd:           bus.result = andRes;
         aluOr:            bus.result = orRes;
         aluAdd, aluSub:   bus.result = sumRes;
         aluXor, aluXnor:  bus.result = xorRes;
         default:          bus.result = '1;      // Unused codes
      endcase
   end

   assign bus.zero     = ~|bus.result;
   // Only a true add reports overflow
   assign bus.overflow = adderOvf & (bus.operation == aluAdd);

endmodule

//--- hw/aluControl.sv
// ALU control decode
// Maps the controller's ALUOp mode and the instruction funct to an ALU operation

module aluControl (
   aluBus.control bus
);
   import datapathCtrlPkg::*;
   import mipsIsaPkg::*;

   always_comb
   begin
      case (bus.mode)
         forceAdd: bus.operation = aluAdd;        // PC step, address calc
         forceSub: bus.operation = aluSub;        // Branch compare
         default:
         begin
            // R-type, funct decides
            case (bus.funct)
               fnAdd:   bus.operation = aluAdd;
               fnSub:   bus.operation = aluSub;
               fnAnd:   bus.operation = aluAnd;
               fnOr:    bus.operation = aluOr;
               fnXor:   bus.operation = aluXor;
               // SLT and unknown codes
               default: bus.operation = aluXnor;
            endcase
         end
      endcase
   end

endmodule

//--- hw/regFile.sv
// 32-entry register file, two asynchronous reads and one clocked write
// Register 0 reads zero and drops writes

module regFile (
   input  logic                   Clock,
   input  logic                   regWrite,
   input  mipsIsaPkg::regIdxT     readIdx1,
   input  mipsIsaPkg::regIdxT     readIdx2,
   input  mipsIsaPkg::regIdxT     writeIdx,
   input  datapathCtrlPkg::wordT  writeData,
   output datapathCtrlPkg::wordT  readData1,
   output datapathCtrlPkg::wordT  readData2
);
   import datapathCtrlPkg::*;
   import mipsIsaPkg::*;

   wordT regs [1:regCount-1];               // No storage behind r0

   // Reads, r0 forced to zero
   assign readData1 = (readIdx1 != '0) ? regs[readIdx1] : '0;
   assign readData2 = (readIdx2 != '0) ? regs[readIdx2] : '0;

   // Write, visible to reads next cycle
   always_ff @(posedge Clock)
   begin
      if (regWrite && (writeIdx != '0))
      begin
         regs[writeIdx] <= writeData;
      end
   end

endmodule

//--- hw/pcUnit.sv
// Program counter with next-PC select and write enable
// Loads on pcWrite, or on pcWriteCond when the ALU reports zero

module pcUnit (
   input  logic                             Clock,
   input  logic                             rstN,
   input  logic                             pcWrite,
   input  logic                             pcWriteCond,   // Branch
   input  datapathCtrlPkg::pcSourceT        pcSource,
   input  logic                             zero,
   input  datapathCtrlPkg::wordT            aluResult,     // Live ALU output
   input  datapathCtrlPkg::wordT            aluHeld,       // ALUOut register
   input  logic [mipsIsaPkg::jumpIdxW-1:0]  jumpIndex,
   output datapathCtrlPkg::wordT            pc
);
   import datapathCtrlPkg::*;

   wordT jumpTarget;
   wordT nextPc;
   logic pcEnable;

   // Upper PC bits kept, index is a word address
   assign jumpTarget = {pc[wordW-1:wordW-4], jumpIndex, 2'b00};

   // ~~~~~~~~~~~~~~~~~ Next-PC select ~~~~~~~~~~~~~~~~
   always_comb
   begin
      case (pcSource)
         pcAlu:    nextPc = aluResult;          // PC + 4
         pcAluReg: nextPc = aluHeld;            // Branch target
         pcJump:   nextPc = jumpTarget;
         default:  nextPc = exceptionVector;
      endcase
   end

   assign pcEnable = pcWrite | (pcWriteCond & zero);

   always_ff @(posedge Clock)
   begin
      if (!rstN)
      begin
         pc <= '0;
      end
      else if (pcEnable)
      begin
         pc <= nextPc;
      end
   end

endmodule

//--- hw/loadAligner.sv
// Register write-back select with byte load
// Byte lane comes from the effective address, lane 0 is the MSB (big-endian)

module loadAligner (
   input  datapathCtrlPkg::wordT mdr,
   input  datapathCtrlPkg::wordT aluHeld,   // Effective address
   input  logic                  memToReg,
   input  logic                  loadByte,
   output datapathCtrlPkg::wordT regWriteData
);
   import datapathCtrlPkg::*;

   logic [byteW-1:0] laneByte;
   wordT             byteExt;

   // Lane pick by address bits 1..0
   always_comb
   begin
      case (aluHeld[1:0])
         2'b00:   laneByte = mdr[31:24];
         2'b01:   laneByte = mdr[23:16];
         2'b10:   laneByte = mdr[15:8];
         default: laneByte = mdr[7:0];
      endcase
   end

   assign byteExt = {{(wordW-byteW){laneByte[byteW-1]}}, laneByte};   // Sign extend

   // Byte load wins over word load
   always_comb
   begin
      if (loadByte)
      begin
         regWriteData = byteExt;
      end
      else if (memToReg)
      begin
         regWriteData = mdr;
      end
      else
      begin
         regWriteData = aluHeld;                // ALU result write-back
      end
   end

endmodule

//--- hw/mipsDatapath.sv
// Multicycle datapath of the 32-bit MIPS-style core, top level
// An external controller drives the strobes and selects cycle by cycle

module mipsDatapath (
   input  logic                        Clock,
   input  logic                        rstN,
   input  logic                        pcWriteCond,   // Branch PC write
   input  logic                        pcWrite,
   input  logic                        iOrD,          // Address from ALUOut
   input  logic                        irWrite,
   input  logic                        memToReg,
   input  logic                        loadByte,
   input  logic                        regWrite,
   input  logic                        regDst,        // Write to rd, else rt
   input  logic                        aluSrcA,       // A register, else PC
   input  datapathCtrlPkg::aluOpModeT  aluOp,
   input  datapathCtrlPkg::srcBSelT    aluSrcB,
   input  datapathCtrlPkg::pcSourceT   pcSource,
   input  datapathCtrlPkg::wordT       memData,
   output datapathCtrlPkg::wordT       address,
   output datapathCtrlPkg::wordT       writeData,
   output mipsIsaPkg::opcodeT          opcode,        // To the controller FSM
   output logic                        overflow       // Registered
);
   import datapathCtrlPkg::*;
   import mipsIsaPkg::*;

   instrT  ir;                               // Instruction register
   wordT   mdr;                              // Memory data register
   wordT   regA;
   wordT   regB;
   wordT   aluHeld;                          // ALUOut register
   wordT   pc;
   wordT   readData1;
   wordT   readData2;
   wordT   regWriteData;
   wordT   immExt;                           // Sign-extended immediate
   wordT   immShift;                         // Same, word offset
   regIdxT writeIdx;

   aluBus aluIf ();

   // ~~~~~~~~~~~~~~~~ Stage registers ~~~~~~~~~~~~~~~~
   always_ff @(posedge Clock)
   begin
      mdr     <= memData;
      regA    <= readData1;
      regB    <= readData2;
      aluHeld <= aluIf.result;
      if (irWrite)
      begin
         ir <= instrT'(memData);
      end
   end

   // Overflow flag, cleared by reset
   always_ff @(posedge Clock)
   begin
      if (!rstN)
      begin
         overflow <= 1'b0;
      end
      else
      begin
         overflow <= aluIf.overflow;
      end
   end

   // ~~~~~~~~~~~~~~~~ Selects and extends ~~~~~~~~~~~~
   assign address  = iOrD ? aluHeld : pc;
   assign writeIdx = regDst ? ir.rd : ir.rt;
   assign immExt   = {{(wordW-immW){ir[immW-1]}}, ir[immW-1:0]};
   assign immShift = immExt << 2;

   // Operands and mode onto the ALU bus
   assign aluIf.opA   = aluSrcA ? regA : pc;
   assign aluIf.funct = functT'(ir.funct);
   assign aluIf.mode  = aluOp;

   always_comb
   begin
      case (aluSrcB)
         selB:     aluIf.opB = regB;
         selFour:  aluIf.opB = pcStep;
         selImm:   aluIf.opB = immExt;
         default:  aluIf.opB = immShift;      // Branch offset
      endcase
   end

   assign writeData = regB;                   // Store data
   assign opcode    = ir.opcode;

   // ~~~~~~~~~~~~~~~~~~~ Instances ~~~~~~~~~~~~~~~~~~~
   pcUnit pcBlk (
      .Clock       (Clock),
      .rstN        (rstN),
      .pcWrite     (pcWrite),
      .pcWriteCond (pcWriteCond),
      .pcSource    (pcSource),
      .zero        (aluIf.zero),
      .aluResult   (aluIf.result),
      .aluHeld     (aluHeld),
      .jumpIndex   (ir[jumpIdxW-1:0]),
      .pc          (pc)
   );

   regFile regs (
      .Clock     (Clock),
      .regWrite  (regWrite),
      .readIdx1  (ir.rs),
      .readIdx2  (ir.rt),
      .writeIdx  (writeIdx),
      .writeData (regWriteData),
      .readData1 (readData1),
      .readData2 (readData2)
   );

   aluControl aluCtl (
      .bus (aluIf.control)
   );

   alu aluBlk (
      .bus (aluIf.compute)
   );

   loadAligner aligner (
      .mdr          (mdr),
      .aluHeld      (aluHeld),
      .memToReg     (memToReg),
      .loadByte     (loadByte),
      .regWriteData (regWriteData)
   );

endmodule

//--- tb/clockGen.sv
// Free-running clock source of the testbench, starts low
// Period comes from the instantiating testbench

module clockGen #(
   parameter int period = 20
) (
   output logic Clock
);
   logic level = 1'b0;                      // Low at time zero

   assign Clock = level;

   always #(period / 2) level = ~level;     // Toggle each half period

endmodule

//--- tb/datapathTb.sv
// Testbench of the multicycle datapath acting as its external controller
// Drives strobes on the falling edge and checks results just after each rising edge

module datapathTb;
   import datapathCtrlPkg::*;
   import mipsIsaPkg::*;

   localparam int edgeLimit = 100;          // Time units allowed per edge wait

   logic      Clock;
   logic      rstN, pcWriteCond, pcWrite, iOrD, irWrite;
   logic      memToReg, loadByte, regWrite, regDst, aluSrcA;
   aluOpModeT aluOp;
   srcBSelT   aluSrcB;
   pcSourceT  pcSource;
   wordT      memData, address, writeData;
   opcodeT    opcode;
   logic      overflow;

   wordT mem [0:255];                       // Word memory on address bits 9..2
   wordT regModel [0:31];                   // Expected register contents
   wordT expPc;                             // Expected PC
   wordT rngState = 32'h16d2fea6;
   int   fallCount;
   int   riseCount;
   logic [5:0] functList [0:6] = '{fnAdd, fnSub, fnAnd, fnOr, fnXor, fnSlt, 6'h3f};

   // Pending expectations consumed after the next rising edge
   wordT   wordExp [$];
   bit     wordOnAddr [$];                  // Set for address, clear for writeData
   opcodeT opExp [$];
   logic   flagExp [$];

   clockGen #(.period(20)) clkSrc (.Clock(Clock));

   mipsDatapath uut (.*);

   assign memData = mem[address[9:2]];      // Asynchronous read

   always @(negedge Clock) fallCount <= fallCount + 1;
   always @(posedge Clock) riseCount <= riseCount + 1;

   function automatic wordT xorshift();
      rngState ^= rngState << 13;
      rngState ^= rngState >> 17;
      rngState ^= rngState << 5;
      return rngState;
   endfunction

   // ~~~~~~~~~~~~~~~~ Reference model ~~~~~~~~~~~~~~~~
   function automatic wordT aluReference(input logic [5:0] fn, input wordT a, input wordT b,
                                         output logic ovf);
      wordT r;
      ovf = 1'b0;
      case (fn)
         fnAdd:
         begin
            r   = a + b;
            ovf = (a[31] == b[31]) && (r[31] != a[31]);   // Equal input signs, sign flips
         end
         fnSub:   r = a - b;                // No overflow report
         fnAnd:   r = a & b;
         fnOr:    r = a | b;
         fnXor:   r = a ^ b;
         default: r = ~(a ^ b);             // SLT and unknown codes
      endcase
      return r;
   endfunction

   function automatic wordT byteReference(input wordT word, input logic [1:0] lane);
      logic [7:0] b;
      b = word[8 * (3 - lane) +: 8];        // Lane 0 is the top byte
      return {{24{b[7]}}, b};
   endfunction

   // ~~~~~~~~~~~~~~~~~~~~ Checks ~~~~~~~~~~~~~~~~~~~~~
   task automatic failRun(input string why);
      $display("%s", why);
      $display("*** FAILED ***");
      $fatal(1);
   endtask

   task automatic checkWord(input string name, input wordT actual, input wordT expected);
      if (actual !== expected)
         failRun($sformatf("Mismatch at %0t: %s expected %h, got %h",
                           $time, name, expected, actual));
   endtask

   task automatic checkOpcode(input string name, input opcodeT actual, input opcodeT expected);
      if (actual !== expected)
         failRun($sformatf("Mismatch at %0t: %s expected %h, got %h",
                           $time, name, expected, actual));
   endtask

   task automatic checkFlag(input string name, input logic actual, input logic expected);
      if (actual !== expected)
         failRun($sformatf("Mismatch at %0t: %s expected %b, got %b",
                           $time, name, expected, actual));
   endtask

   task automatic expectWord(input bit onAddr, input wordT value);
      wordOnAddr.push_back(onAddr);
      wordExp.push_back(value);
   endtask

   // Compare process runs one step after every rising edge
   initial
   begin : compare
      int seen;
      int waited;
      forever
      begin
         seen   = riseCount;
         waited = 0;
         while (riseCount == seen)
         begin
            #1;
            waited++;
            if (waited > edgeLimit)
               failRun("Timeout: the clock stopped rising");
         end
         while (wordExp.size() > 0)
         begin
            if (wordOnAddr.pop_front())
               checkWord("address", address, wordExp.pop_front());
            else
               checkWord("writeData", writeData, wordExp.pop_front());
         end
         while (opExp.size() > 0)
            checkOpcode("opcode", opcode, opExp.pop_front());
         while (flagExp.size() > 0)
            checkFlag("overflow", overflow, flagExp.pop_front());
      end
   end

   // ~~~~~~~~~~~~~~~ Controller steps ~~~~~~~~~~~~~~~
   task automatic nextCycle();
      int start;
      int waited;
      start  = fallCount;
      waited = 0;
      while (fallCount == start)
      begin
         #1;
         waited++;
         if (waited > edgeLimit)
            failRun("Timeout: the clock stopped falling");
      end
   endtask

   task automatic idle();
      {pcWriteCond, pcWrite, iOrD, irWrite, memToReg} = '0;
      {loadByte, regWrite, regDst, aluSrcA} = '0;
      aluOp    = forceAdd;
      aluSrcB  = selFour;                   // Keeps ALU inputs defined
      pcSource = pcAlu;
   endtask

   task automatic fetch(input wordT instr);
      idle();
      mem[expPc[9:2]] = instr;
      irWrite = 1'b1;
      pcWrite = 1'b1;                       // PC + 4 from the live ALU
      expectWord(1'b1, expPc + 32'd4);
      opExp.push_back(opcodeT'(instr[31:26]));
      nextCycle();
      expPc = expPc + 32'd4;
   endtask

   task automatic decode();
      idle();
      aluSrcB = selImmShift;                // Branch target into ALUOut
      nextCycle();
   endtask

   task automatic readBack(input regIdxT idx);
      fetch({opSw, 5'd0, idx, 16'd0});      // rt selects B
      expectWord(1'b0, regModel[idx]);
      decode();
   endtask

   task automatic loadFromMemory(input regIdxT rt, input wordT ea, input wordT word,
                                 input bit isByte);
      fetch({isByte ? opLb : opLw, 5'd0, rt, ea[15:0]});
      decode();
      idle();
      aluSrcA = 1'b1;
      aluSrcB = selImm;                     // ALUOut holds ea to write-back
      nextCycle();
      mem[ea[9:2]] = word;
      iOrD = 1'b1;
      nextCycle();
      memToReg = !isByte;
      loadByte = isByte;
      regWrite = 1'b1;
      nextCycle();
      if (rt != 5'd0)
         regModel[rt] = isByte ? byteReference(word, ea[1:0]) : word;
      readBack(rt);
   endtask

   task automatic runRType(input regIdxT rs, input regIdxT rt, input regIdxT rd,
                           input logic [5:0] fn);
      wordT result;
      logic ovf;
      fetch({opRType, rs, rt, rd, 5'd0, fn});
      decode();
      result  = aluReference(fn, regModel[rs], regModel[rt], ovf);
      idle();
      aluSrcA = 1'b1;
      aluSrcB = selB;
      aluOp   = byFunct;
      flagExp.push_back(ovf);               // Registered at the execute edge
      nextCycle();
      regDst   = 1'b1;
      regWrite = 1'b1;
      nextCycle();
      if (rd != 5'd0)
         regModel[rd] = result;
      readBack(rd);
   endtask

   task automatic branch(input regIdxT rs, input regIdxT rt, input logic [15:0] off);
      wordT target;
      fetch({opBeq, rs, rt, off});
      target = expPc + {{14{off[15]}}, off, 2'b00};
      decode();
      idle();
      aluSrcA     = 1'b1;
      aluSrcB     = selB;
      aluOp       = forceSub;               // Zero when operands equal
      pcWriteCond = 1'b1;
      pcSource    = pcAluReg;
      if (regModel[rs] == regModel[rt])
         expPc = target;
      expectWord(1'b1, expPc);
      nextCycle();
   endtask

   task automatic jumpTo(input logic [25:0] index);
      fetch({opJ, index});
      idle();
      pcWrite  = 1'b1;
      pcSource = pcJump;
      expPc    = {expPc[31:28], index, 2'b00};   // Upper PC bits kept
      expectWord(1'b1, expPc);
      nextCycle();
   endtask

   // ~~~~~~~~~~~~~~~~~~~~ Stimulus ~~~~~~~~~~~~~~~~~~~
   initial
   begin : stimulus
      int   waited;
      wordT rnd;
      for (int i = 0; i < 256; i++)
         mem[i] = 32'h9e3779b9 * (i + 1);  // Distinct per word address
      regModel[0] = '0;
      expPc       = '0;
      rstN        = 1'b0;
      idle();
      expectWord(1'b1, 32'd0);              // PC cleared by the first reset edge
      flagExp.push_back(1'b0);              // Overflow register cleared as well
      waited = 0;
      while (riseCount == 0)
      begin
         #1;
         waited++;
         if (waited > edgeLimit)
            failRun("Timeout: the clock never started");
      end
      nextCycle();
      nextCycle();
      rstN = 1'b1;

      // Word loads with r9 and r10 large positive
      for (int r = 1; r <= 10; r++)
      begin
         rnd = xorshift();
         if (r >= 9)
            rnd = (rnd | 32'h6000_0000) & 32'h7fff_ffff;
         loadFromMemory(regIdxT'(r), 32'h200 + 4 * r, rnd, 1'b0);
      end
      loadFromMemory(5'd0, 32'h280, xorshift(), 1'b0);   // r0 stays zero

      runRType(5'd9, 5'd10, 5'd11, fnAdd);  // Overflows
      // Every funct code twice on random registers
      for (int n = 0; n < 14; n++)
      begin
         rnd = xorshift();
         runRType(regIdxT'(1 + rnd[3:0] % 10), regIdxT'(1 + rnd[7:4] % 10),
                  regIdxT'(11 + rnd[11:8] % 10), functList[n % 7]);
      end

      branch(5'd3, 5'd3, 16'd6);            // Taken
      branch(5'd1, 5'd2, 16'hfffd);
      branch(5'd0, 5'd0, 16'hfff0);         // Backward and taken

      idle();
      pcWrite  = 1'b1;
      pcSource = pcVector;
      expPc    = 32'hc000_0000;
      expectWord(1'b1, expPc);
      nextCycle();
      rnd = xorshift();
      jumpTo(rnd[25:0]);

      for (int lane = 0; lane < 4; lane++)
         loadFromMemory(regIdxT'(21 + lane), 32'h300 + lane, xorshift(), 1'b1);

      if (wordExp.size() + opExp.size() + flagExp.size() != 0)
         failRun("Some expected results were never checked");
      else
      begin
         $display("*** PASSED ***");
         $finish;
      end
   end

endmodule

//--- build.f
hw/mipsIsaPkg.sv
hw/datapathCtrlPkg.sv
hw/aluBus.sv
hw/claAdder.sv
hw/alu.sv
hw/aluControl.sv
hw/regFile.sv
hw/pcUnit.sv
hw/loadAligner.sv
hw/mipsDatapath.sv
tb/clockGen.sv
tb/datapathTb.sv
